// File: tb.f
source/elink_cfg_pkg.sv
source/ecfg_regs.sv
source/ecfg_reset_seq.sv
source/ecfg_clk_div.sv
source/elink_cfg_top.sv
dv/elink_cfg_tb.sv

// File: run.sh
#!/bin/sh
# build and run the link configuration testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module elink_cfg_tb -o elink_cfg_sim

# capture output even when the simulation stops on an error
out=$(./obj_dir/elink_cfg_sim 2>&1 || true)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "NO ERRORS"; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi

// File: dv/elink_cfg_tb.sv
/*
 testbench for the link configuration block
 host strobes driven on the falling edge
 concurrent assertions compare the outputs with a shadow model of the registers
*/
`timescale 1ns/1ps

module elink_cfg_tb import elink_cfg_pkg::*; ();

   logic        sys_clk;
   logic        hard_reset;
   mi_req_t     mi_req;
   logic [31:0] mi_dout;
   logic        link_reset;
   logic        tick;
   logic [15:0] clk_settings;
   logic [3:0]  row_id;
   logic [3:0]  col_id;

   // shadow of the register file
   logic                 sh_reset;
   logic [15:0]          sh_clk;
   logic [11:0]          sh_coreid;
   logic [15:0]          sh_version;
   logic [31:0]          exp_dout;           // readback expected after a read
   logic [reg_idx_w-1:0] req_idx;
   logic                 exp_link;
   int                   hold_left;          // release countdown after soft reset falls
   logic                 run_now;            // divider allowed to count
   int                   period;
   int                   gap;                // samples since run start or last tick
   int                   tick_cnt;
   string                test_name;

   elink_cfg_top i_dut (
      .sys_clk      (sys_clk),
      .hard_reset   (hard_reset),
      .mi_req       (mi_req),
      .mi_dout      (mi_dout),
      .link_reset   (link_reset),
      .tick         (tick),
      .clk_settings (clk_settings),
      .row_id       (row_id),
      .col_id       (col_id)
   );

   initial begin
      sys_clk = 1'b0;
      forever #4 sys_clk = ~sys_clk;         // 8 ns
   end

   // ##########################################################
   // failure reporting
   // ##########################################################
   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("ERRORS FOUND");
      $fatal(1);
   endtask

   task automatic report_mismatch(input string what, input logic [31:0] exp,
                                  input logic [31:0] act);
      fail_run($sformatf("error %s %s expected %h actual %h", test_name, what, exp, act));
   endtask

   // ##########################################################
   // shadow model
   // ##########################################################

   // readback as the register map defines it
   function automatic logic [31:0] read_value(input logic [reg_idx_w-1:0] idx);
      logic [31:0] val;
      val = 32'h0;                           // unmapped reads zero
      if (idx == reg_reset)
         val = {31'h0, sh_reset};
      else if (idx == reg_clk)
         val = {24'h0, sh_clk[7:0]};         // low byte only
      else if (idx == reg_coreid)
         val = {20'h0, sh_coreid};
      else if (idx == reg_version)
         val = {16'h0, sh_version};
      return val;
   endfunction

   assign req_idx = mi_req.addr[reg_idx_w+1:2];
   assign run_now = sh_clk[4] & ~exp_link;   // clk_en is bit 4
   assign period  = int'(sh_clk[3:0]) + 1;

   always @(posedge sys_clk) begin
      if (hard_reset) begin
         sh_reset   <= 1'b0;
         sh_clk     <= 16'h0;
         sh_coreid  <= default_coreid;
         sh_version <= default_version;
         exp_dout   <= 32'h0;
      end else if (mi_req.en && mi_req.we) begin
         if (req_idx == reg_reset)
            sh_reset <= mi_req.din[0];
         else if (req_idx == reg_clk)
            sh_clk <= mi_req.din[15:0];
         else if (req_idx == reg_coreid)
            sh_coreid <= mi_req.din[11:0];
         else if (req_idx == reg_version)
            sh_version <= mi_req.din[15:0];
      end else if (mi_req.en) begin
         exp_dout <= read_value(req_idx);    // shown one cycle later
      end
   end

   // link reset rises one cycle late and falls hold plus one cycles late
   always @(posedge sys_clk) begin
      if (hard_reset) begin
         exp_link  <= 1'b0;
         hold_left <= 0;
      end else if (sh_reset) begin
         exp_link  <= 1'b1;
         hold_left <= reset_hold_cycles;
      end else if (hold_left != 0) begin
         hold_left <= hold_left - 1;
      end else begin
         exp_link <= 1'b0;
      end
   end

   always @(posedge sys_clk) begin
      if (hard_reset) begin
         gap      <= 0;
         tick_cnt <= 0;
      end else begin
         if (tick)
            tick_cnt <= tick_cnt + 1;
         if (!run_now)
            gap <= 0;                        // count restarts
         else if (tick)
            gap <= 1;
         else
            gap <= gap + 1;
      end
   end

   // ##########################################################
   // checks
   // ##########################################################
   a_dout: assert property (@(posedge sys_clk) disable iff (hard_reset)
      mi_dout == exp_dout)
      else report_mismatch("mi_dout", $sampled(exp_dout), $sampled(mi_dout));

   a_clk_settings: assert property (@(posedge sys_clk) disable iff (hard_reset)
      clk_settings == sh_clk)
      else report_mismatch("clk_settings", 32'($sampled(sh_clk)), 32'($sampled(clk_settings)));

   a_row: assert property (@(posedge sys_clk) disable iff (hard_reset)
      row_id == sh_coreid[11:8])
      else report_mismatch("row_id", 32'($sampled(sh_coreid[11:8])), 32'($sampled(row_id)));

   a_col: assert property (@(posedge sys_clk) disable iff (hard_reset)
      col_id == sh_coreid[5:2])
      else report_mismatch("col_id", 32'($sampled(sh_coreid[5:2])), 32'($sampled(col_id)));

   a_link: assert property (@(posedge sys_clk) disable iff (hard_reset)
      link_reset == exp_link)
      else report_mismatch("link_reset", 32'($sampled(exp_link)), 32'($sampled(link_reset)));

   a_tick_in_reset: assert property (@(posedge sys_clk) disable iff (hard_reset)
      tick |-> !exp_link)
      else fail_run("tick seen while the link reset was high");

   a_tick_enabled: assert property (@(posedge sys_clk) disable iff (hard_reset)
      tick |-> $past(run_now))
      else fail_run("tick seen while the divider was disabled");

   a_tick_gap: assert property (@(posedge sys_clk) disable iff (hard_reset)
      (run_now && tick) |-> gap == period)
      else report_mismatch("tick spacing", $sampled(period), $sampled(gap));

   a_tick_due: assert property (@(posedge sys_clk) disable iff (hard_reset)
      run_now |-> gap <= period)
      else fail_run("expected tick did not arrive");

   // ##########################################################
   // host stimulus
   // ##########################################################
   task automatic write_reg(input logic [reg_idx_w-1:0] idx, input logic [31:0] data);
      mi_req.en   = 1'b1;
      mi_req.we   = 1'b1;
      mi_req.addr = {13'h0, idx, 2'b00};
      mi_req.din  = data;
      @(negedge sys_clk);
      mi_req = '0;
   endtask

   task automatic read_reg(input logic [reg_idx_w-1:0] idx);
      mi_req.en   = 1'b1;
      mi_req.we   = 1'b0;
      mi_req.addr = {13'h0, idx, 2'b00};
      mi_req.din  = 32'h0;
      @(negedge sys_clk);
      mi_req = '0;
   endtask

   task automatic idle(input int cycles);
      repeat (cycles) @(negedge sys_clk);
   endtask

   task automatic wait_link(input logic level, input int limit);
      int n;
      n = 0;
      while (link_reset !== level && n < limit) begin
         @(negedge sys_clk);
         n++;
      end
      if (link_reset !== level)
         fail_run("timeout waiting for the link reset to change");
   endtask

   task automatic wait_ticks(input int count, input int limit);
      int start;
      int n;
      start = tick_cnt;
      n = 0;
      while (tick_cnt < start + count && n < limit) begin
         @(negedge sys_clk);
         n++;
      end
      if (tick_cnt < start + count)
         fail_run("timeout waiting for divider ticks");
   endtask

   // pll_mult parked at 10 with reserved bits zero
   function automatic logic [31:0] clk_word(input logic en, input logic [3:0] div);
      return {16'h0, 7'h0, 4'ha, en, div};
   endfunction

   initial begin
      logic [31:0] data;
      logic [3:0]  div_set [5];
      void'($urandom(32'hf850fb5e));
      div_set    = '{4'd0, 4'd1, 4'd3, 4'd7, 4'd15};
      mi_req     = '0;
      hard_reset = 1'b1;
      test_name  = "reset";
      repeat (5) @(negedge sys_clk);
      hard_reset = 1'b0;

      test_name = "reset_values";
      for (int i = 0; i < 4; i++)
         read_reg(reg_idx_w'(i));

      test_name = "random_write";
      for (int n = 0; n < 8; n++) begin
         for (int i = 0; i < 4; i++) begin
            data = $urandom();
            if (reg_idx_w'(i) == reg_clk)
               data[4] = 1'b0;               // keep the divider idle here
            write_reg(reg_idx_w'(i), data);
            read_reg(reg_idx_w'(i));
         end
      end

      test_name = "unmapped";
      read_reg(reg_version);
      for (int i = 4; i < 32; i++)
         read_reg(reg_idx_w'(i));

      test_name = "soft_reset";
      write_reg(reg_reset, 32'h0);          // random bit may have left it set
      wait_link(1'b0, reset_hold_cycles + 4);
      write_reg(reg_reset, 32'h1);
      wait_link(1'b1, 4);
      idle(5);
      write_reg(reg_reset, 32'h0);
      wait_link(1'b0, reset_hold_cycles + 4);

      test_name = "tick_period";
      foreach (div_set[k]) begin
         write_reg(reg_clk, clk_word(1'b0, div_set[k]));
         write_reg(reg_clk, clk_word(1'b1, div_set[k]));
         wait_ticks(3, 3 * 17 + 8);
      end
      write_reg(reg_clk, clk_word(1'b0, 4'd2));
      idle(40);                              // disabled window

      test_name = "tick_after_reset";
      write_reg(reg_clk, clk_word(1'b1, 4'd4));
      wait_ticks(1, 20);
      write_reg(reg_reset, 32'h1);
      wait_link(1'b1, 4);
      idle(10);
      write_reg(reg_reset, 32'h0);
      wait_link(1'b0, reset_hold_cycles + 4);
      wait_ticks(2, 20);

      idle(4);
      $display("NO ERRORS");
      $finish;
   end

endmodule

// File: source/elink_cfg_top.sv
/*
 top of the link configuration block
 host strobes in, link reset, tick, chip ids and raw clock settings out
*/
`timescale 1ns/1ps

module elink_cfg_top import elink_cfg_pkg::*; (
   input  logic         sys_clk,
   input  logic         hard_reset,
   input  mi_req_t      mi_req,
   output logic [31:0]  mi_dout,
   output logic         link_reset,
   output logic         tick,
   output logic [15:0]  clk_settings,
   output logic [3:0]   row_id,
   output logic [3:0]   col_id
);

   logic      soft_reset;                        // register bit to sequencer
   ecfg_clk_u clk_cfg;

   ecfg_regs i_regs (
      .sys_clk    (sys_clk),
      .hard_reset (hard_reset),
      .mi_req     (mi_req),
      .mi_dout    (mi_dout),
      .soft_reset (soft_reset),
      .clk_cfg    (clk_cfg),
      .row_id     (row_id),
      .col_id     (col_id)
   );

   ecfg_reset_seq i_reset_seq (
      .sys_clk    (sys_clk),
      .hard_reset (hard_reset),
      .soft_reset (soft_reset),
      .link_reset (link_reset)
   );

   // divider held while the link is in reset
   ecfg_clk_div i_clk_div (
      .sys_clk    (sys_clk),
      .hard_reset (hard_reset),
      .clk_cfg    (clk_cfg),
      .link_reset (link_reset),
      .tick       (tick)
   );

   assign clk_settings = clk_cfg.raw;            // pll settings as written

endmodule

// File: source/ecfg_clk_div.sv
/*
 transmit tick divider
 one cycle tick every clk_div+1 cycles while clk_en is set and the link is out of reset
*/
`timescale 1ns/1ps

module ecfg_clk_div import elink_cfg_pkg::*; (
   input  logic      sys_clk,
   input  logic      hard_reset,
   input  ecfg_clk_u clk_cfg,
   input  logic      link_reset,
   output logic      tick
);

   logic [div_w-1:0] cnt;
   logic [div_w-1:0] div_q;                      // period latched at start of period
   logic [div_w-1:0] div_eff;
   logic             run;
   logic             tick_q;

   assign run     = clk_cfg.fields.clk_en & ~link_reset;
   assign div_eff = (cnt == '0) ? clk_cfg.fields.clk_div : div_q; // new divide at wrap

   always_ff @(posedge sys_clk) begin
      if (hard_reset) begin
         cnt    <= '0;
         tick_q <= 1'b0;
      end else if (!run) begin
         cnt    <= '0;                           // restart on hold or disable
         tick_q <= 1'b0;
      end else if (cnt == div_eff) begin
         cnt    <= '0;
         tick_q <= 1'b1;
      end else begin
         cnt    <= cnt + 1'b1;
         tick_q <= 1'b0;
      end
   end

   // capture the period at each period start
   always_ff @(posedge sys_clk) begin
      if (cnt == '0)
         div_q <= clk_cfg.fields.clk_div;
   end

   assign tick = tick_q & ~link_reset;           // no tick leaks into a fresh link reset

   // tick low under link reset, count parked at zero from the next cycle
   a_no_tick_in_reset: assert property (
      @(posedge sys_clk) disable iff (hard_reset)
      link_reset |-> !tick ##1 (!link_reset || cnt == '0)
   );

endmodule

// File: source/ecfg_reset_seq.sv
/*
 link reset sequencer
 follows the soft reset bit and stretches its release by a fixed hold time
 so the link sees a clean minimum reset pulse
*/
`timescale 1ns/1ps

module ecfg_reset_seq import elink_cfg_pkg::*; (
   input  logic sys_clk,
   input  logic hard_reset,
   input  logic soft_reset,
   output logic link_reset
);

   logic [1:0]            state;
   logic [hold_cnt_w-1:0] hold_cnt;              // cycles left in hold, minus one

   // ##########################################################
   // state machine
   // ##########################################################
   always_ff @(posedge sys_clk) begin
      if (hard_reset) begin
         state    <= st_idle;
         hold_cnt <= '0;
      end else begin
         case (state)
            st_idle: begin
               if (soft_reset)
                  state <= st_asserted;
            end
            st_asserted: begin
               if (!soft_reset) begin
                  state    <= st_hold;
                  hold_cnt <= hold_last;         // preload full hold
               end
            end
            st_hold: begin
               if (soft_reset)
                  state <= st_asserted;          // re-armed mid hold
               else if (hold_cnt == '0)
                  state <= st_idle;
               else
                  hold_cnt <= hold_cnt - 1'b1;
            end
            default: state <= st_idle;
         endcase
      end
   end

   // high in asserted and hold
   assign link_reset = (state != st_idle);

   // ##########################################################
   // checks
   // ##########################################################

   // soft reset always reaches the link one cycle later
   a_follow: assert property (
      @(posedge sys_clk) disable iff (hard_reset)
      soft_reset |=> link_reset
   );

   a_hold_range: assert property (
      @(posedge sys_clk) disable iff (hard_reset)
      hold_cnt <= hold_last
   );

endmodule

// File: source/ecfg_regs.sv
/*
 memory mapped configuration registers of the link
 full 32-bit word writes only, readback registered one cycle after the read strobe
 all registers cleared by hard_reset alone
*/
`timescale 1ns/1ps

module ecfg_regs import elink_cfg_pkg::*; (
   input  logic         sys_clk,
   input  logic         hard_reset,
   input  mi_req_t      mi_req,
   output logic [31:0]  mi_dout,
   output logic         soft_reset,
   output ecfg_clk_u    clk_cfg,
   output logic [3:0]   row_id,
   output logic [3:0]   col_id
);

   logic [reg_idx_w-1:0] idx;                    // word index from byte address
   logic                 wr;
   logic                 rd;

   logic                 reset_q;
   ecfg_clk_u            clk_q;
   ecfg_coreid_u         coreid_q;
   logic [15:0]          version_q;

   // ##########################################################
   // decode
   // ##########################################################
   assign idx = mi_req.addr[reg_idx_w+1:2];
   assign wr  = mi_req.en & mi_req.we;
   assign rd  = mi_req.en & ~mi_req.we;

   // ##########################################################
   // writable registers
   // ##########################################################

   // soft reset bit, level to the sequencer
   always_ff @(posedge sys_clk) begin
      if (hard_reset)
         reset_q <= 1'b0;
      else if (wr && idx == reg_reset)
         reset_q <= mi_req.din[0];
   end

   // clock settings, zero after reset so tick is off
   always_ff @(posedge sys_clk) begin
      if (hard_reset)
         clk_q.raw <= '0;
      else if (wr && idx == reg_clk)
         clk_q.raw <= mi_req.din[15:0];
   end

   always_ff @(posedge sys_clk) begin
      if (hard_reset)
         coreid_q.raw <= default_coreid;
      else if (wr && idx == reg_coreid)
         coreid_q.raw <= mi_req.din[11:0];
   end

   always_ff @(posedge sys_clk) begin
      if (hard_reset)
         version_q <= default_version;
      else if (wr && idx == reg_version)
         version_q <= mi_req.din[15:0];
   end

   assign soft_reset = reset_q;
   assign clk_cfg    = clk_q;
   assign row_id     = coreid_q.fields.row_id;    // bits 11:8
   assign col_id     = coreid_q.fields.col_id;    // bits 5:2

   // ##########################################################
   // readback
   // ##########################################################

   // one cycle pipeline, dout held between reads
   always_ff @(posedge sys_clk) begin
      if (hard_reset) begin
         mi_dout <= '0;
      end else if (rd) begin
         case (idx)
            reg_reset:   mi_dout <= {31'b0, reset_q};
            reg_clk:     mi_dout <= {24'b0, clk_q.raw[7:0]};  // low byte only
            reg_coreid:  mi_dout <= {20'b0, coreid_q.raw};
            reg_version: mi_dout <= {16'b0, version_q};
            default:     mi_dout <= '0;                       // unmapped
         endcase
      end
   end

   // unmapped index reads back as zero on the following cycle
   a_unmapped_zero: assert property (
      @(posedge sys_clk) disable iff (hard_reset)
      (rd && idx > reg_version) |=> (mi_dout == '0)
   );

endmodule

// File: source/elink_cfg_pkg.sv
/*
 shared definitions for the link configuration block
 register map, reset timing constants, register views and host request
 imported by wildcard into every module of the block
*/
package elink_cfg_pkg;

   // ##########################################################
   // register map
   // ##########################################################
   localparam int reg_idx_w = 5;                    // word index, addr[6:2]

   localparam logic [reg_idx_w-1:0] reg_reset   = 5'd0;
   localparam logic [reg_idx_w-1:0] reg_clk     = 5'd1;
   localparam logic [reg_idx_w-1:0] reg_coreid  = 5'd2;
   localparam logic [reg_idx_w-1:0] reg_version = 5'd3;

   localparam logic [11:0] default_coreid  = 12'h808; // row 8, col 2
   localparam logic [15:0] default_version = 16'h0000;

   // ##########################################################
   // reset sequencer
   // ##########################################################
   localparam int reset_hold_cycles = 16;           // link reset stretch after soft reset
   localparam int hold_cnt_w        = $clog2(reset_hold_cycles + 1);
   localparam logic [hold_cnt_w-1:0] hold_last = hold_cnt_w'(reset_hold_cycles - 1);

   // sequencer state codes
   localparam logic [1:0] st_idle     = 2'd0;
   localparam logic [1:0] st_asserted = 2'd1;
   localparam logic [1:0] st_hold     = 2'd2;

   localparam int div_w = 4;                        // tick divider width

   // clock settings word, written whole, read as fields by the divider
   typedef union packed {
      logic [15:0] raw;
      struct packed {
         logic [6:0]       rsvd;
         logic [3:0]       pll_mult;               // passed straight out to the pll
         logic             clk_en;
         logic [div_w-1:0] clk_div;                // tick period minus one
      } fields;
   } ecfg_clk_u;

   // chip coordinates word
   typedef union packed {
      logic [11:0] raw;
      struct packed {
         logic [3:0] row_id;
         logic [1:0] rsvd_hi;
         logic [3:0] col_id;
         logic [1:0] rsvd_lo;
      } fields;
   } ecfg_coreid_u;

   // host strobes, no handshake
   typedef struct packed {
      logic        en;
      logic        we;                             // 1 = write, 0 = read
      logic [19:0] addr;                           // byte address
      logic [31:0] din;
   } mi_req_t;

endpackage
